//--- source/iagc_pkg.sv
package iagc_pkg;

    localparam int ADC_W    = 14;   // Width of one ADC channel.
    localparam int SAMPLE_W = 16;   // Stored width of one channel after sign extension.
    localparam int BYTE_W   = 8;    // Width of the command and transmit streams.
    localparam int DECIM_W  = 4;

    // Values loaded by reset.
    localparam logic [DECIM_W-1:0] DEF_DECIMATOR = 4'd3;
    localparam logic [3:0]         DEF_SIZE_CODE = 4'd2;

    // One stored memory word. The reference channel sits in the upper half.
    typedef struct packed {
        logic [SAMPLE_W-1:0] ref_sample;
        logic [SAMPLE_W-1:0] err_sample;
    } sample_pair_t;

    // Opcode in the upper nibble of a command byte.
    typedef enum logic [3:0] {
        CMD_NOP           = 4'd0,
        CMD_SET_DECIMATOR = 4'd1,
        CMD_SET_SIZE      = 4'd2,
        CMD_CLEAN         = 4'd3,
        CMD_CAPTURE       = 4'd4,
        CMD_DUMP          = 4'd5
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_CLEAN   = 2'd1,
        ST_CAPTURE = 2'd2
    } status_e;

endpackage

//--- source/mem_port_if.sv
interface mem_port_if #(
    parameter int ADDR_W = 10
);
    import iagc_pkg::*;

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    sample_pair_t      wdata;
    logic              gnt;
    logic              rdata_valid;     // Marks rdata one cycle after a read grant.
    sample_pair_t      rdata;           // RAM output, shared by every port.

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata_valid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata_valid, rdata
    );

endinterface

//--- source/iagc_controller.sv
module iagc_controller #(
    parameter int MEM_DEPTH = 1024,
    parameter int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic                          i_clock,
    input  logic                          i_arst_n,
    input  logic [iagc_pkg::BYTE_W-1:0]   i_cmd_data,
    input  logic                          i_cmd_valid,
    output logic                          o_cmd_ready,
    input  logic                          i_capture_end,
    input  logic                          i_dump_busy,
    output logic                          o_capture_start,
    output logic                          o_dump_start,
    output logic [iagc_pkg::DECIM_W-1:0]  o_decimator,
    output logic [ADDR_W:0]               o_capture_len,
    output iagc_pkg::status_e             o_status,
    mem_port_if.requester                 clean_port
);
    import iagc_pkg::*;

    opcode_e           cmd_op;
    logic [3:0]        cmd_param;
    logic              cmd_take;
    logic [3:0]        size_code;
    logic [ADDR_W-1:0] clean_addr;
    logic [31:0]       full_len;

    assign cmd_op      = opcode_e'(i_cmd_data[BYTE_W-1 -: 4]);
    assign cmd_param   = i_cmd_data[3:0];
    assign o_cmd_ready = (o_status != ST_CLEAN);    // Commands wait while memory is cleaned.
    assign cmd_take    = i_cmd_valid && o_cmd_ready;

    // Capture length is 16 words shifted by the size code, capped at the memory depth.
    assign full_len      = 32'd16 << size_code;
    assign o_capture_len = (full_len > MEM_DEPTH) ? (ADDR_W + 1)'(MEM_DEPTH)
                                                  : full_len[ADDR_W:0];

    assign clean_port.req   = (o_status == ST_CLEAN);
    assign clean_port.we    = 1'b1;
    assign clean_port.addr  = clean_addr;
    assign clean_port.wdata = '0;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_status        <= ST_IDLE;
            o_decimator     <= DEF_DECIMATOR;
            size_code       <= DEF_SIZE_CODE;
            clean_addr      <= '0;
            o_capture_start <= 1'b0;
            o_dump_start    <= 1'b0;
        end else begin
            o_capture_start <= 1'b0;
            o_dump_start    <= 1'b0;

            // A dump is legal in idle and in capture. A second start while one runs is dropped.
            if (cmd_take && cmd_op == CMD_DUMP) begin
                o_dump_start <= !i_dump_busy && !o_dump_start;
            end

            case (o_status)
                ST_IDLE: begin
                    if (cmd_take) begin
                        case (cmd_op)
                            CMD_SET_DECIMATOR: o_decimator <= cmd_param;
                            CMD_SET_SIZE:      size_code   <= cmd_param;
                            CMD_CLEAN: begin
                                o_status   <= ST_CLEAN;
                                clean_addr <= '0;
                            end
                            CMD_CAPTURE: begin
                                o_status        <= ST_CAPTURE;
                                o_capture_start <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                ST_CLEAN: begin
                    // One zero word per granted cycle until the last address is written.
                    if (clean_port.gnt) begin
                        if (clean_addr == ADDR_W'(MEM_DEPTH - 1)) begin
                            o_status <= ST_IDLE;
                        end else begin
                            clean_addr <= clean_addr + 1'b1;
                        end
                    end
                end
                ST_CAPTURE: begin
                    if (i_capture_end) begin
                        o_status <= ST_IDLE;
                    end
                end
                default: o_status <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/sample_decimator.sv
module sample_decimator (
    input  logic                          i_clock,
    input  logic                          i_arst_n,
    input  logic                          i_enable,
    input  logic                          i_gate,
    input  logic [iagc_pkg::DECIM_W-1:0]  i_decimator,
    output logic                          o_strobe
);
    import iagc_pkg::*;

    logic [DECIM_W-1:0] count;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            count    <= '0;
            o_strobe <= 1'b0;
        end else if (!i_enable) begin
            count    <= '0;                 // Every capture starts from a fresh count.
            o_strobe <= 1'b0;
        end else if (i_gate) begin
            if (count == i_decimator) begin
                count    <= '0;
                o_strobe <= 1'b1;
            end else begin
                count    <= count + 1'b1;
                o_strobe <= 1'b0;
            end
        end else begin
            o_strobe <= 1'b0;               // Gate low holds the count.
        end
    end

endmodule

//--- source/capture_sampler.sv
module capture_sampler #(
    parameter int MEM_DEPTH = 1024,
    parameter int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic                         i_clock,
    input  logic                         i_arst_n,
    input  logic                         i_start,
    input  logic                         i_strobe,
    input  logic [iagc_pkg::ADC_W-1:0]   i_adc_ref,
    input  logic [iagc_pkg::ADC_W-1:0]   i_adc_err,
    input  logic [ADDR_W:0]              i_capture_len,
    output logic                         o_end,
    mem_port_if.requester                samp_port
);
    import iagc_pkg::*;

    logic              active;
    logic              take;
    logic              req_q;
    logic [ADDR_W:0]   taken;       // Strobes accepted in this capture.
    logic [ADDR_W-1:0] addr_q;
    sample_pair_t      pair_in;
    sample_pair_t      pair_q;

    assign pair_in.ref_sample = {{(SAMPLE_W - ADC_W){i_adc_ref[ADC_W-1]}}, i_adc_ref};
    assign pair_in.err_sample = {{(SAMPLE_W - ADC_W){i_adc_err[ADC_W-1]}}, i_adc_err};

    // Strobes past the capture length are ignored.
    assign take = active && i_strobe && (taken < i_capture_len);

    assign samp_port.req   = req_q;
    assign samp_port.we    = 1'b1;
    assign samp_port.addr  = addr_q;
    assign samp_port.wdata = pair_q;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            active <= 1'b0;
            taken  <= '0;
            req_q  <= 1'b0;
            o_end  <= 1'b0;
        end else begin
            o_end <= 1'b0;
            if (i_start) begin
                active <= 1'b1;
                taken  <= '0;
                req_q  <= 1'b0;
            end else begin
                if (take) begin
                    req_q <= 1'b1;
                    taken <= taken + 1'b1;
                end else if (samp_port.gnt) begin
                    req_q <= 1'b0;
                end
                // The grant of the last word closes the capture.
                if (req_q && samp_port.gnt && taken == i_capture_len) begin
                    active <= 1'b0;
                    o_end  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (take) begin
            addr_q <= taken[ADDR_W-1:0];
            pair_q <= pair_in;
        end
    end

endmodule

//--- source/dump_unit.sv
module dump_unit #(
    parameter int MEM_DEPTH = 1024,
    parameter int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic                         i_clock,
    input  logic                         i_arst_n,
    input  logic                         i_start,
    input  logic [ADDR_W:0]              i_dump_len,
    output logic                         o_busy,
    output logic [iagc_pkg::BYTE_W-1:0]  o_tx_data,
    output logic                         o_tx_valid,
    input  logic                         i_tx_ready,
    mem_port_if.requester                dump_port
);
    import iagc_pkg::*;

    localparam int WORD_W     = $bits(sample_pair_t);
    localparam int WORD_BYTES = WORD_W / BYTE_W;
    localparam int CNT_W      = $clog2(WORD_BYTES) + 1;

    logic [ADDR_W:0]   word_cnt;     // Words requested so far.
    logic [ADDR_W:0]   len_q;
    logic              pending;      // A read was granted and its data is due.
    logic [CNT_W-1:0]  bytes_left;
    logic [WORD_W-1:0] shift_buf;
    logic              tx_take;

    assign o_tx_valid = (bytes_left != '0);
    assign o_tx_data  = shift_buf[WORD_W-1 -: BYTE_W];  // Most significant byte first.
    assign tx_take    = o_tx_valid && i_tx_ready;

    // The next word is fetched only once the buffer has drained.
    assign dump_port.req   = o_busy && !pending && !o_tx_valid && (word_cnt < len_q);
    assign dump_port.we    = 1'b0;
    assign dump_port.addr  = word_cnt[ADDR_W-1:0];
    assign dump_port.wdata = '0;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_busy     <= 1'b0;
            word_cnt   <= '0;
            len_q      <= '0;
            pending    <= 1'b0;
            bytes_left <= '0;
        end else begin
            if (i_start && !o_busy) begin
                o_busy   <= 1'b1;
                word_cnt <= '0;
                len_q    <= i_dump_len;
            end
            if (dump_port.req && dump_port.gnt) begin
                pending  <= 1'b1;
                word_cnt <= word_cnt + 1'b1;
            end
            if (dump_port.rdata_valid) begin
                pending    <= 1'b0;
                bytes_left <= CNT_W'(WORD_BYTES);
            end else if (tx_take) begin
                bytes_left <= bytes_left - 1'b1;
                if (bytes_left == CNT_W'(1) && word_cnt == len_q) begin
                    o_busy <= 1'b0;                 // Last byte of the last word.
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (dump_port.rdata_valid) begin
            shift_buf <= dump_port.rdata;
        end else if (tx_take) begin
            shift_buf <= shift_buf << BYTE_W;
        end
    end

endmodule

//--- source/mem_arbiter.sv
module mem_arbiter #(
    parameter int MEM_DEPTH = 1024,
    parameter int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    mem_port_if.arbiter            samp_port,
    mem_port_if.arbiter            clean_port,
    mem_port_if.arbiter            dump_port,
    output logic                   o_ram_we,
    output logic [ADDR_W-1:0]      o_ram_addr,
    output iagc_pkg::sample_pair_t o_ram_wdata,
    input  iagc_pkg::sample_pair_t i_ram_rdata
);

    // The sampler cannot stall a strobe, so it always wins. Clean beats dump.
    assign samp_port.gnt  = samp_port.req;
    assign clean_port.gnt = clean_port.req && !samp_port.req;
    assign dump_port.gnt  = dump_port.req && !samp_port.req && !clean_port.req;

    always_comb begin
        o_ram_we    = 1'b0;
        o_ram_addr  = dump_port.addr;
        o_ram_wdata = dump_port.wdata;
        if (samp_port.gnt) begin
            o_ram_we    = samp_port.we;
            o_ram_addr  = samp_port.addr;
            o_ram_wdata = samp_port.wdata;
        end else if (clean_port.gnt) begin
            o_ram_we    = clean_port.we;
            o_ram_addr  = clean_port.addr;
            o_ram_wdata = clean_port.wdata;
        end else if (dump_port.gnt) begin
            o_ram_we = dump_port.we;
        end
    end

    assign samp_port.rdata  = i_ram_rdata;
    assign clean_port.rdata = i_ram_rdata;
    assign dump_port.rdata  = i_ram_rdata;

    // The RAM answers one cycle after a read grant. Remember who asked.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            samp_port.rdata_valid  <= 1'b0;
            clean_port.rdata_valid <= 1'b0;
            dump_port.rdata_valid  <= 1'b0;
        end else begin
            samp_port.rdata_valid  <= samp_port.gnt && !samp_port.we;
            clean_port.rdata_valid <= clean_port.gnt && !clean_port.we;
            dump_port.rdata_valid  <= dump_port.gnt && !dump_port.we;
        end
    end

endmodule

//--- source/sample_ram.sv
module sample_ram #(
    parameter int MEM_DEPTH = 1024,
    parameter int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic                   i_clock,
    input  logic                   i_we,
    input  logic [ADDR_W-1:0]      i_addr,
    input  iagc_pkg::sample_pair_t i_wdata,
    output iagc_pkg::sample_pair_t o_rdata
);
    import iagc_pkg::*;

    sample_pair_t mem [MEM_DEPTH];

    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];     // Registered read, old data on a write.
    end

endmodule

//--- source/iagc_top.sv
module iagc_top #(
    parameter int MEM_DEPTH = 1024
) (
    input  logic                         i_clock,
    input  logic                         i_arst_n,
    input  logic [iagc_pkg::BYTE_W-1:0]  i_cmd_data,
    input  logic                         i_cmd_valid,
    output logic                         o_cmd_ready,
    input  logic                         i_gate,
    input  logic [iagc_pkg::ADC_W-1:0]   i_adc_ref,
    input  logic [iagc_pkg::ADC_W-1:0]   i_adc_err,
    output logic [iagc_pkg::BYTE_W-1:0]  o_tx_data,
    output logic                         o_tx_valid,
    input  logic                         i_tx_ready,
    output iagc_pkg::status_e            o_status
);
    import iagc_pkg::*;

    localparam int ADDR_W = $clog2(MEM_DEPTH);

    logic               capture_start;
    logic               capture_end;
    logic               capture_active;
    logic               dump_start;
    logic               dump_busy;
    logic               strobe;
    logic [DECIM_W-1:0] decimator;
    logic [ADDR_W:0]    capture_len;
    logic               ram_we;
    logic [ADDR_W-1:0]  ram_addr;
    sample_pair_t       ram_wdata;
    sample_pair_t       ram_rdata;

    mem_port_if #(.ADDR_W(ADDR_W)) samp_port  ();
    mem_port_if #(.ADDR_W(ADDR_W)) clean_port ();
    mem_port_if #(.ADDR_W(ADDR_W)) dump_port  ();

    assign capture_active = (o_status == ST_CAPTURE);

    iagc_controller #(
        .MEM_DEPTH       ( MEM_DEPTH       ),
        .ADDR_W          ( ADDR_W          )
    ) u_iagc_controller (
        .i_clock         ( i_clock         ),
        .i_arst_n        ( i_arst_n        ),
        .i_cmd_data      ( i_cmd_data      ),
        .i_cmd_valid     ( i_cmd_valid     ),
        .o_cmd_ready     ( o_cmd_ready     ),
        .i_capture_end   ( capture_end     ),
        .i_dump_busy     ( dump_busy       ),
        .o_capture_start ( capture_start   ),
        .o_dump_start    ( dump_start      ),
        .o_decimator     ( decimator       ),
        .o_capture_len   ( capture_len     ),
        .o_status        ( o_status        ),
        .clean_port      ( clean_port      )
    );

    sample_decimator u_sample_decimator (
        .i_clock         ( i_clock         ),
        .i_arst_n        ( i_arst_n        ),
        .i_enable        ( capture_active  ),
        .i_gate          ( i_gate          ),
        .i_decimator     ( decimator       ),
        .o_strobe        ( strobe          )
    );

    capture_sampler #(
        .MEM_DEPTH       ( MEM_DEPTH       ),
        .ADDR_W          ( ADDR_W          )
    ) u_capture_sampler (
        .i_clock         ( i_clock         ),
        .i_arst_n        ( i_arst_n        ),
        .i_start         ( capture_start   ),
        .i_strobe        ( strobe          ),
        .i_adc_ref       ( i_adc_ref       ),
        .i_adc_err       ( i_adc_err       ),
        .i_capture_len   ( capture_len     ),
        .o_end           ( capture_end     ),
        .samp_port       ( samp_port       )
    );

    dump_unit #(
        .MEM_DEPTH       ( MEM_DEPTH       ),
        .ADDR_W          ( ADDR_W          )
    ) u_dump_unit (
        .i_clock         ( i_clock         ),
        .i_arst_n        ( i_arst_n        ),
        .i_start         ( dump_start      ),
        .i_dump_len      ( capture_len     ),
        .o_busy          ( dump_busy       ),
        .o_tx_data       ( o_tx_data       ),
        .o_tx_valid      ( o_tx_valid      ),
        .i_tx_ready      ( i_tx_ready      ),
        .dump_port       ( dump_port       )
    );

    mem_arbiter #(
        .MEM_DEPTH       ( MEM_DEPTH       ),
        .ADDR_W          ( ADDR_W          )
    ) u_mem_arbiter (
        .i_clock         ( i_clock         ),
        .i_arst_n        ( i_arst_n        ),
        .samp_port       ( samp_port       ),
        .clean_port      ( clean_port      ),
        .dump_port       ( dump_port       ),
        .o_ram_we        ( ram_we          ),
        .o_ram_addr      ( ram_addr        ),
        .o_ram_wdata     ( ram_wdata       ),
        .i_ram_rdata     ( ram_rdata       )
    );

    sample_ram #(
        .MEM_DEPTH       ( MEM_DEPTH       ),
        .ADDR_W          ( ADDR_W          )
    ) u_sample_ram (
        .i_clock         ( i_clock         ),
        .i_we            ( ram_we          ),
        .i_addr          ( ram_addr        ),
        .i_wdata         ( ram_wdata       ),
        .o_rdata         ( ram_rdata       )
    );

endmodule

//--- dv/iagc_asserts.sv
module iagc_asserts (
    input logic                         i_clock,
    input logic                         i_arst_n,
    input logic [iagc_pkg::BYTE_W-1:0]  i_tx_data,
    input logic                         i_tx_valid,
    input logic                         i_tx_ready,
    input logic                         i_cmd_ready,
    input iagc_pkg::status_e            i_status
);
    timeunit 1ns;
    timeprecision 100ps;
    import iagc_pkg::*;

    int assert_errors = 0;      // Read by the testbench at the end of the run.

    // A stalled byte must be held until the receiver takes it.
    tx_hold: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data)))
    else begin
        assert_errors++;
        $error("Transmit byte changed while stalled.");
    end

    tx_quiet_after_reset: assert property (@(posedge i_clock)
        $rose(i_arst_n) |-> !i_tx_valid)
    else begin
        assert_errors++;
        $error("Transmit valid seen in the first cycle after reset.");
    end

    // Commands are refused while memory is being cleaned.
    no_cmd_in_clean: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_status == ST_CLEAN) |-> !i_cmd_ready)
    else begin
        assert_errors++;
        $error("Command ready raised during clean.");
    end

endmodule

//--- dv/tb_iagc_tasks.svh
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic [SAMPLE_W-1:0] sign_extend(input logic [ADC_W-1:0] value);
    return SAMPLE_W'($signed(value));
endfunction

task automatic check_bit(input string sig, input logic act, input logic exp);
    compares++;
    if (act !== exp) begin
        errors++;
        $display("Fail %0d ns %s: got %b expected %b", $time, sig, act, exp);
    end
endtask

task automatic check_byte(input string sig, input logic [BYTE_W-1:0] act,
                          input logic [BYTE_W-1:0] exp);
    compares++;
    if (act !== exp) begin
        errors++;
        $display("Fail %0d ns %s: got %h expected %h", $time, sig, act, exp);
    end
endtask

task automatic check_status(input string sig, input status_e act, input status_e exp);
    compares++;
    if (act !== exp) begin
        errors++;
        $display("Fail %0d ns %s: got %s expected %s", $time, sig, act.name(), exp.name());
    end
endtask

task automatic check_pair(input string sig, input sample_pair_t act, input sample_pair_t exp);
    compares++;
    if (act !== exp) begin
        errors++;
        $display("Fail %0d ns %s: got %h expected %h", $time, sig, act, exp);
    end
endtask

// Holds the byte on the bus until the DUT raises ready, then drops valid.
task automatic send_cmd(input opcode_e op, input logic [3:0] param);
    int cycles;
    cycles = 0;
    @(posedge clock);
    cmd_data  <= {op, param};
    cmd_valid <= 1'b1;
    @(negedge clock);
    while (!cmd_ready && cycles < WAIT_LIMIT) begin
        @(negedge clock);
        cycles++;
    end
    if (!cmd_ready) begin
        abort_run($sformatf("command %s was never accepted", op.name()));
    end
    @(posedge clock);           // The byte is taken on this edge.
    cmd_valid <= 1'b0;
endtask

task automatic wait_status(input status_e want, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (status !== want && cycles < limit) begin
        @(negedge clock);
        cycles++;
    end
    if (status !== want) begin
        abort_run($sformatf("status did not reach %s in %0d cycles", want.name(), limit));
    end
endtask

// Ready is driven on the rising edge. A byte counts when valid and ready are both high.
task automatic collect_bytes(input int count, input bit random_ready);
    int          cycles;
    logic [31:0] rnd;
    cycles = 0;
    rx_bytes.delete();
    while (rx_bytes.size() < count && cycles < WAIT_LIMIT) begin
        rnd = lcg_next();
        @(posedge clock);
        tx_ready <= random_ready ? rnd[20] : 1'b1;
        @(negedge clock);
        if (tx_valid && tx_ready) begin
            rx_bytes.push_back(tx_data);
        end
        cycles++;
    end
    if (rx_bytes.size() < count) begin
        abort_run($sformatf("only %0d of %0d dump bytes arrived", rx_bytes.size(), count));
    end
    @(posedge clock);
    tx_ready <= 1'b0;
endtask

task automatic expect_tx_quiet(input int cycles);
    repeat (cycles) begin
        @(negedge clock);
        check_bit("o_tx_valid", tx_valid, 1'b0);
    end
endtask

// Rebuilds words from the byte stream and checks the sample spacing.
task automatic check_capture_words(input logic [DECIM_W-1:0] decim, input int words);
    int               k;
    sample_pair_t     got;
    sample_pair_t     want;
    logic [ADC_W-1:0] base;
    logic [ADC_W-1:0] value;
    base = '0;
    for (k = 0; k < words; k++) begin
        got = {rx_bytes[4*k], rx_bytes[4*k+1], rx_bytes[4*k+2], rx_bytes[4*k+3]};
        if (k == 0) begin
            base = got.ref_sample[ADC_W-1:0];
        end
        value           = base + ADC_W'(k * (decim + 1));
        want.ref_sample = sign_extend(value);
        want.err_sample = sign_extend(~value);      // Error input is the complement.
        check_pair($sformatf("o_tx_data word %0d", k), got, want);
    end
endtask

//--- dv/tb_iagc.sv
module tb_iagc;
    timeunit 1ns;
    timeprecision 100ps;
    import iagc_pkg::*;

    localparam int MEM_DEPTH  = 1024;
    localparam int WAIT_LIMIT = 5000;
    localparam int SMALL_LEN  = 16;     // Words captured with size code 0.

    logic               clock;
    logic               arst_n;
    logic [BYTE_W-1:0]  cmd_data;
    logic               cmd_valid;
    logic               cmd_ready;
    logic               gate;
    logic [ADC_W-1:0]   adc_ref;
    logic [ADC_W-1:0]   adc_err;
    logic [BYTE_W-1:0]  tx_data;
    logic               tx_valid;
    logic               tx_ready;
    status_e            status;

    int                 errors;
    int                 compares;
    int                 timeouts;
    logic [31:0]        lcg_state;
    logic [BYTE_W-1:0]  rx_bytes[$];
    logic [BYTE_W-1:0]  ref_bytes[$];

    iagc_top #(.MEM_DEPTH(MEM_DEPTH)) UUT (
        .i_clock     ( clock     ),
        .i_arst_n    ( arst_n    ),
        .i_cmd_data  ( cmd_data  ),
        .i_cmd_valid ( cmd_valid ),
        .o_cmd_ready ( cmd_ready ),
        .i_gate      ( gate      ),
        .i_adc_ref   ( adc_ref   ),
        .i_adc_err   ( adc_err   ),
        .o_tx_data   ( tx_data   ),
        .o_tx_valid  ( tx_valid  ),
        .i_tx_ready  ( tx_ready  ),
        .o_status    ( status    )
    );

    bind iagc_top iagc_asserts u_iagc_asserts (
        .i_clock     ( i_clock     ),
        .i_arst_n    ( i_arst_n    ),
        .i_tx_data   ( o_tx_data   ),
        .i_tx_valid  ( o_tx_valid  ),
        .i_tx_ready  ( i_tx_ready  ),
        .i_cmd_ready ( o_cmd_ready ),
        .i_status    ( o_status    )
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // The ADC model is a free-running ramp. The error channel is its complement.
    always @(posedge clock) begin
        adc_ref <= adc_ref + 1'b1;
        adc_err <= ~(adc_ref + 1'b1);
    end

    `include "tb_iagc_tasks.svh"

    task automatic finish_run();
        int total;
        total = errors + timeouts + UUT.u_iagc_asserts.assert_errors;
        $display("Summary: %0d compares, %0d mismatches, %0d timeouts, %0d assertion errors",
                 compares, errors, timeouts, UUT.u_iagc_asserts.assert_errors);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string what);
        timeouts++;
        $display("Timeout at %0d ns: %s", $time, what);
        finish_run();
    endtask

    task automatic reset_defaults();
        @(negedge clock);
        check_status("o_status", status, ST_IDLE);
        check_bit("o_cmd_ready", cmd_ready, 1'b1);
        check_bit("o_tx_valid", tx_valid, 1'b0);
    endtask

    task automatic clean_then_dump();
        int i;
        send_cmd(CMD_CLEAN, 4'd0);
        @(negedge clock);
        check_status("o_status", status, ST_CLEAN);
        check_bit("o_cmd_ready", cmd_ready, 1'b0);
        wait_status(ST_IDLE, WAIT_LIMIT);
        send_cmd(CMD_DUMP, 4'd0);
        collect_bytes(4 * 64, 1'b0);        // Default size code gives 64 words.
        for (i = 0; i < rx_bytes.size(); i++) begin
            check_byte($sformatf("o_tx_data byte %0d", i), rx_bytes[i], 8'h00);
        end
        expect_tx_quiet(8);
        check_status("o_status", status, ST_IDLE);
    endtask

    task automatic capture_then_dump(input logic [DECIM_W-1:0] decim);
        send_cmd(CMD_SET_DECIMATOR, decim);
        send_cmd(CMD_SET_SIZE, 4'd0);
        @(posedge clock);
        gate <= 1'b1;
        send_cmd(CMD_CAPTURE, 4'd0);
        @(negedge clock);
        check_status("o_status", status, ST_CAPTURE);
        wait_status(ST_IDLE, WAIT_LIMIT);
        send_cmd(CMD_DUMP, 4'd0);
        collect_bytes(4 * SMALL_LEN, 1'b0);
        check_capture_words(decim, SMALL_LEN);
        ref_bytes = rx_bytes;
        expect_tx_quiet(8);
    endtask

    // Same memory contents, so the stream must match the last dump byte for byte.
    task automatic dump_with_random_ready();
        int i;
        send_cmd(CMD_DUMP, 4'd0);
        collect_bytes(4 * SMALL_LEN, 1'b1);
        for (i = 0; i < ref_bytes.size(); i++) begin
            check_byte($sformatf("o_tx_data byte %0d", i), rx_bytes[i], ref_bytes[i]);
        end
        expect_tx_quiet(8);
    endtask

    task automatic gated_capture(input logic [DECIM_W-1:0] decim);
        @(posedge clock);
        gate <= 1'b0;
        send_cmd(CMD_CAPTURE, 4'd0);
        repeat (200) begin
            @(negedge clock);
            check_status("o_status", status, ST_CAPTURE);
        end
        @(posedge clock);
        gate <= 1'b1;
        wait_status(ST_IDLE, WAIT_LIMIT);
        send_cmd(CMD_DUMP, 4'd0);
        collect_bytes(4 * SMALL_LEN, 1'b0);
        check_capture_words(decim, SMALL_LEN);
        expect_tx_quiet(8);
    endtask

    // The dump competes with the sampler for the memory port.
    task automatic dump_while_capturing(input logic [DECIM_W-1:0] decim);
        send_cmd(CMD_SET_DECIMATOR, decim);
        send_cmd(CMD_CAPTURE, 4'd0);
        send_cmd(CMD_DUMP, 4'd0);
        @(negedge clock);
        check_status("o_status", status, ST_CAPTURE);
        collect_bytes(4 * SMALL_LEN, 1'b0);
        expect_tx_quiet(8);
        wait_status(ST_IDLE, WAIT_LIMIT);
    endtask

    initial begin
        errors    = 0;
        compares  = 0;
        timeouts  = 0;
        lcg_state = 32'd36258;
        arst_n    <= 1'b0;
        cmd_data  <= '0;
        cmd_valid <= 1'b0;
        gate      <= 1'b0;
        adc_ref   <= '0;
        adc_err   <= '1;
        tx_ready  <= 1'b0;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;
        reset_defaults();
        clean_then_dump();
        capture_then_dump(4'd2);
        dump_with_random_ready();
        gated_capture(4'd2);
        dump_while_capturing(4'd5);
        finish_run();
    end

endmodule

//--- filelist.f
+incdir+dv
source/iagc_pkg.sv
source/mem_port_if.sv
source/iagc_controller.sv
source/sample_decimator.sv
source/capture_sampler.sv
source/dump_unit.sv
source/mem_arbiter.sv
source/sample_ram.sv
source/iagc_top.sv
dv/iagc_asserts.sv
dv/tb_iagc.sv

//--- Bender.yml
package:
  name: iagc

sources:
  - files:
      - source/iagc_pkg.sv
      - source/mem_port_if.sv
      - source/iagc_controller.sv
      - source/sample_decimator.sv
      - source/capture_sampler.sv
      - source/dump_unit.sv
      - source/mem_arbiter.sv
      - source/sample_ram.sv
      - source/iagc_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/iagc_asserts.sv
      - dv/tb_iagc.sv
